/* src/nocPkg.sv */
package nocPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // router geometry and flit encoding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // inputs in order L, N, E, W, S
  localparam int NUM_PORTS = 5;

  typedef logic [2:0]  flitIdT;
  typedef logic [11:0] pktLenT;
  typedef logic [31:0] flitDataT;

  // index into the input array
  typedef logic [$clog2(NUM_PORTS)-1:0] portIdxT;

  // head flit carries the packet length
  localparam flitIdT FLIT_HEAD = 3'b001;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-input request bundle and output flit
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic     req;
    flitIdT   flitId;
    pktLenT   length;
    flitDataT data;
  } portReqT;

  typedef struct packed {
    logic     valid;
    flitDataT data;
  } outFlitT;

endpackage

/* src/arbPkg.sv */
package arbPkg;

  // one-hot arbiter state, bit 0 is idle and bits 5:1 follow the port order
  typedef enum logic [5:0] {
    ST_IDLE = 6'b000001,
    ST_L    = 6'b000010,
    ST_N    = 6'b000100,
    ST_E    = 6'b001000,
    ST_W    = 6'b010000,
    ST_S    = 6'b100000
  } arbStateT;

  // one bit per input, same order as the input array
  typedef logic [nocPkg::NUM_PORTS-1:0] grantT;

endpackage

/* src/sliceTimer.sv */
`timescale 1ns/1ps

module sliceTimer (
  input  logic           clk,
  input  logic           rst,
  input  nocPkg::flitIdT flitId,
  input  nocPkg::pktLenT length,
  input  logic           run,
  output logic           timesUp
);

  import nocPkg::*;

  pktLenT limit;
  pktLenT count;

  // limit follows the latest head flit on this input
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (flitId == FLIT_HEAD)
    begin
      limit <= length;
    end
  end

  // counts only while the holder keeps the slice
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

/* src/outputArbiter.sv */
`timescale 1ns/1ps

module outputArbiter (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::portReqT inPorts [nocPkg::NUM_PORTS],
  output arbPkg::grantT   grant
);

  import nocPkg::*;
  import arbPkg::*;

  arbStateT state;
  arbStateT nextState;
  grantT    reqVec;
  grantT    timesUpVec;
  grantT    runVec;
  grantT    holder;
  portIdxT  holderIdx;
  logic     stay;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // rotation helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // first requester at or after first, cyclic
  function automatic grantT pickFrom(input grantT reqs, input portIdxT first);
    grantT   pick;
    portIdxT idx;
    pick = '0;
    // walk backwards so the closest requester wins
    for (int k = NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = portIdxT'((int'(first) + k) % NUM_PORTS);
      if (reqs[idx])
      begin
        pick = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  // cyclic successor of a port
  function automatic portIdxT nextPort(input portIdxT idx);
    portIdxT succ;
    if (idx == portIdxT'(NUM_PORTS - 1))
    begin
      succ = '0;
    end
    else
    begin
      succ = idx + 1'b1;
    end
    return succ;
  endfunction

  // no grant maps back to idle
  function automatic arbStateT toState(input grantT g);
    arbStateT st;
    if (g == '0)
    begin
      st = ST_IDLE;
    end
    else
    begin
      st = arbStateT'({g, 1'b0});
    end
    return st;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-input slice timers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      reqVec[i] = inPorts[i].req;
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : genTimer
    sliceTimer sliceTimer_inst (
      .clk     (clk),
      .rst     (rst),
      .flitId  (inPorts[p].flitId),
      .length  (inPorts[p].length),
      .run     (runVec[p]),
      .timesUp (timesUpVec[p])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign holder = state[NUM_PORTS:1];
  assign grant  = holder;

  // only the holder can run, and only while it keeps its slice
  assign runVec = holder & reqVec & ~timesUpVec;
  assign stay   = |runVec;

  always_comb
  begin
    case (state)
      ST_L:    holderIdx = portIdxT'(0);
      ST_N:    holderIdx = portIdxT'(1);
      ST_E:    holderIdx = portIdxT'(2);
      ST_W:    holderIdx = portIdxT'(3);
      ST_S:    holderIdx = portIdxT'(4);
      default: holderIdx = '0;
    endcase
  end

  always_comb
  begin
    nextState = ST_IDLE;
    case (state)
      // fixed order L, N, E, W, S
      ST_IDLE:
      begin
        nextState = toState(pickFrom(reqVec, '0));
      end
      ST_L, ST_N, ST_E, ST_W, ST_S:
      begin
        if (stay)
        begin
          nextState = state;
        end
        else
        begin
          // rotate past the holder, holder itself excluded
          nextState = toState(pickFrom(reqVec & ~holder, nextPort(holderIdx)));
        end
      end
      default:
      begin
        nextState = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

endmodule

/* src/flitForward.sv */
`timescale 1ns/1ps

module flitForward (
  input  logic            clk,
  input  logic            rst,
  input  arbPkg::grantT   grant,
  input  nocPkg::portReqT inPorts [nocPkg::NUM_PORTS],
  output nocPkg::outFlitT outFlit
);

  import nocPkg::*;

  logic     anyGrant;
  flitDataT selData;
  logic     validQ;
  flitDataT dataQ;

  // and-or mux, grant is one-hot
  always_comb
  begin
    selData = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant[i])
      begin
        selData = selData | inPorts[i].data;
      end
    end
  end

  assign anyGrant = |grant;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      validQ <= 1'b0;
    end
    else
    begin
      validQ <= anyGrant;
    end
  end

  always_ff @(posedge clk)
  begin
    dataQ <= selData;
  end

  assign outFlit = '{valid: validQ, data: dataQ};

endmodule

/* src/outputPort.sv */
`timescale 1ns/1ps

module outputPort (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::portReqT inPorts [nocPkg::NUM_PORTS],
  output arbPkg::grantT   grant,
  output nocPkg::outFlitT outFlit
);

  // grant is registered in the arbiter
  outputArbiter outputArbiter_inst (
    .clk     (clk),
    .rst     (rst),
    .inPorts (inPorts),
    .grant   (grant)
  );

  // one more register stage to the output
  flitForward flitForward_inst (
    .clk     (clk),
    .rst     (rst),
    .grant   (grant),
    .inPorts (inPorts),
    .outFlit (outFlit)
  );

endmodule

/* verification/outputPort_assertions.sv */
`timescale 1ns/1ps

module outputPortAssertions (
  input logic            clk,
  input logic            rst,
  input nocPkg::portReqT inPorts [nocPkg::NUM_PORTS],
  input arbPkg::grantT   grant,
  input nocPkg::outFlitT outFlit
);

  import nocPkg::*;
  import arbPkg::*;

  grantT reqVec;
  int    assertErrors = 0;

  always_comb
  begin
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      reqVec[i] = inPorts[i].req;
    end
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else
    begin
      $error("grant is not one-hot or zero: %b", grant);
      assertErrors++;
    end

  // a new grant needs a request one cycle earlier
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : genReqCheck
    grantHadReq: assert property (@(posedge clk) disable iff (rst)
      $rose(grant[p]) |-> $past(reqVec[p]))
      else
      begin
        $error("grant bit %0d raised without a request", p);
        assertErrors++;
      end
  end

  validFollowsGrant: assert property (@(posedge clk) disable iff (rst)
    outFlit.valid == $past(|grant))
    else
    begin
      $error("outFlit.valid does not follow the previous grant");
      assertErrors++;
    end

endmodule

/* verification/outputPortTb.sv */
`timescale 1ns/1ps

module outputPortTb;

  import nocPkg::*;
  import arbPkg::*;

  localparam int CLK_HALF   = 20;
  localparam int WAIT_LIMIT = 200;

  logic    clk;
  logic    rst;
  portReqT inPorts [NUM_PORTS];
  grantT   grant;
  outFlitT outFlit;

  // reference model where holder -1 means idle
  int      mHolder;
  pktLenT  mLimit [NUM_PORTS];
  pktLenT  mCount [NUM_PORTS];
  grantT   expGrant;
  outFlitT expOut;

  int grantErrors = 0;
  int outErrors   = 0;
  int holdErrors  = 0;
  int waitErrors  = 0;

  outputPort outputPort_inst (
    .clk     (clk),
    .rst     (rst),
    .inPorts (inPorts),
    .grant   (grant),
    .outFlit (outFlit)
  );

  bind outputPort outputPortAssertions outputPortAssertions_inst (
    .clk     (clk),
    .rst     (rst),
    .inPorts (inPorts),
    .grant   (grant),
    .outFlit (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int refNextHolder(input int holder, input grantT reqs, input grantT tUp);
    int nxt;
    int first;
    int span;
    int p;
    nxt = -1;
    if (holder >= 0 && reqs[holder] && !tUp[holder])
    begin
      nxt = holder;
    end
    else
    begin
      // idle scans from L and a holder from the port after it
      first = (holder < 0) ? 0 : holder + 1;
      span  = (holder < 0) ? NUM_PORTS : NUM_PORTS - 1;
      for (int k = 0; k < span; k++)
      begin
        p = (first + k) % NUM_PORTS;
        if (nxt < 0 && reqs[p])
        begin
          nxt = p;
        end
      end
    end
    return nxt;
  endfunction

  task automatic checkGrant(input grantT exp, input grantT act);
    if (act !== exp)
    begin
      grantErrors++;
      $display("[FAIL] grant expected %h got %h at %0t", exp, act, $time);
    end
  endtask

  task automatic checkOut(input outFlitT exp, input outFlitT act);
    if (act.valid !== exp.valid || (exp.valid && act.data !== exp.data))
    begin
      outErrors++;
      $display("[FAIL] outFlit expected %h got %h at %0t", exp, act, $time);
    end
  endtask

  task automatic checkHold(input pktLenT exp, input pktLenT act);
    if (act !== exp)
    begin
      holdErrors++;
      $display("[FAIL] hold length expected %h got %h at %0t", exp, act, $time);
    end
  endtask

  // outputs are stable at the falling edge
  initial
  begin : compareProc
    grantT reqs;
    grantT tUp;
    logic  run;
    int    nxt;
    forever
    begin
      @(negedge clk);
      if (rst)
      begin
        mHolder  = -1;
        expGrant = '0;
        expOut   = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
          mLimit[i] = '0;
          mCount[i] = '0;
        end
      end
      else
      begin
        checkGrant(expGrant, grant);
        checkOut(expOut, outFlit);
        for (int i = 0; i < NUM_PORTS; i++)
        begin
          reqs[i] = inPorts[i].req;
          tUp[i]  = (mCount[i] == mLimit[i]);
        end
        run = (mHolder >= 0) && reqs[mHolder] && !tUp[mHolder];
        nxt = refNextHolder(mHolder, reqs, tUp);
        expOut = '0;
        if (mHolder >= 0)
        begin
          expOut.valid = 1'b1;
          expOut.data  = inPorts[mHolder].data;
        end
        for (int i = 0; i < NUM_PORTS; i++)
        begin
          if (inPorts[i].flitId == FLIT_HEAD)
          begin
            mLimit[i] = inPorts[i].length;
          end
          mCount[i] = (run && i == mHolder) ? mCount[i] + 1'b1 : '0;
        end
        mHolder  = nxt;
        expGrant = '0;
        if (mHolder >= 0)
        begin
          expGrant[mHolder] = 1'b1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic driveRandom(input int bias);
    @(posedge clk);
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      inPorts[i].req    <= (($urandom % 100) < bias);
      inPorts[i].flitId <= flitIdT'($urandom % 8);
      inPorts[i].length <= pktLenT'($urandom % 13);
      inPorts[i].data   <= $urandom;
    end
  endtask

  task automatic waitGrant(input int port);
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!grant[port] && cycles < WAIT_LIMIT);
    if (!grant[port])
    begin
      waitErrors++;
      $display("timed out waiting for a grant on port %0d", port);
    end
  endtask

  // called at a falling edge with the grant already high
  task automatic measureHold(input int port, output int held);
    held = 0;
    do
    begin
      held++;
      @(negedge clk);
    end
    while (grant[port] && held < WAIT_LIMIT);
    if (grant[port])
    begin
      waitErrors++;
      $display("grant on port %0d was never released", port);
    end
  endtask

  initial
  begin : stimulus
    int     held;
    pktLenT newLen;
    int     biases [4];
    biases  = '{20, 60, 95, 40};
    void'($urandom(32'h1fb2e0e4));
    rst = 1'b1;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      inPorts[i] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (6) @(posedge clk);

    // head flits everywhere before all request at once
    @(posedge clk);
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      inPorts[i].flitId <= FLIT_HEAD;
      inPorts[i].length <= (i == 3) ? pktLenT'(12) : pktLenT'($urandom % 13);
      inPorts[i].data   <= $urandom;
    end
    @(posedge clk);
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      inPorts[i].flitId <= '0;
      inPorts[i].req    <= 1'b1;
    end

    // west releases early
    waitGrant(3);
    @(posedge clk);
    inPorts[3].req <= 1'b0;
    repeat (4) @(posedge clk);

    for (int b = 0; b < 4; b++)
    begin
      repeat (60) driveRandom(biases[b]);
    end

    // new limit on N governs its next hold
    for (int r = 0; r < 2; r++)
    begin
      newLen = pktLenT'($urandom % 13);
      @(posedge clk);
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        inPorts[i].req    <= 1'b0;
        inPorts[i].flitId <= '0;
      end
      inPorts[1].flitId <= FLIT_HEAD;
      inPorts[1].length <= newLen;
      @(posedge clk);
      inPorts[1].flitId <= '0;
      inPorts[1].req    <= 1'b1;
      waitGrant(1);
      measureHold(1, held);
      checkHold(newLen + 1'b1, pktLenT'(held));
    end

    @(posedge clk);
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      inPorts[i].req <= 1'b0;
    end
    repeat (5) @(posedge clk);
    $display("errors: grant %0d, outFlit %0d, hold %0d, timeout %0d, assertion %0d",
             grantErrors, outErrors, holdErrors, waitErrors,
             outputPort_inst.outputPortAssertions_inst.assertErrors);
    if (grantErrors + outErrors + holdErrors + waitErrors +
        outputPort_inst.outputPortAssertions_inst.assertErrors == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial
  begin : watchdog
    repeat (4000) @(posedge clk);
    $display("simulation stalled, watchdog expired");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* all.f */
src/nocPkg.sv
src/arbPkg.sv
src/sliceTimer.sv
src/outputArbiter.sv
src/flitForward.sv
src/outputPort.sv
verification/outputPort_assertions.sv
verification/outputPortTb.sv

/* Bender.yml */
package:
  name: outputPort

sources:
  - src/nocPkg.sv
  - src/arbPkg.sv
  - src/sliceTimer.sv
  - src/outputArbiter.sv
  - src/flitForward.sv
  - src/outputPort.sv
  - target: simulation
    files:
      - verification/outputPort_assertions.sv
      - verification/outputPortTb.sv
